/* source/ctrlPkg.sv */
package ctrlPkg;

  // Instruction bits 31:12, bit 20 read as S or as L depending on class
  typedef union packed {
    struct packed {
      logic [3:0] cond;                          // Condition code
      logic [1:0] op;                            // Instruction class
      logic       immFlag;                       // Operand 2 is immediate
      logic [3:0] cmd;                           // ALU command
      logic       sBit;                          // Set flags
      logic [3:0] rn;                            // First source
      logic [3:0] rd;                            // Destination
    } dp;
    struct packed {
      logic [3:0] cond;
      logic [1:0] op;
      logic       notImm;                        // Register offset when set
      logic       preIndex;                      // P bit
      logic       up;                            // Add offset when set
      logic       byteFlag;                      // Byte transfer
      logic       writeBack;                     // Base update
      logic       load;                          // LDR when set, STR otherwise
      logic [3:0] rn;                            // Base register
      logic [3:0] rd;                            // Transfer register
    } mem;
  } instrFieldsU;

  localparam logic [1:0] OpDataProc   = 2'b00;  // Data processing
  localparam logic [1:0] OpMemory     = 2'b01;  // LDR and STR
  localparam logic [1:0] OpBranch     = 2'b10;  // B

  localparam logic [3:0] CmdAdd       = 4'b0100;
  localparam logic [3:0] CmdSub       = 4'b0010;
  localparam logic [3:0] CmdRsb       = 4'b0011; // Operands swapped
  localparam logic [3:0] CmdRsc       = 4'b0111; // Operands swapped
  localparam logic [1:0] CmdCmpGroup  = 2'b10;   // TST TEQ CMP CMN, upper cmd bits

  localparam int         FlagN        = 3;
  localparam int         FlagZ        = 2;
  localparam int         FlagC        = 1;
  localparam int         FlagV        = 0;

  localparam logic [1:0] FwdNone      = 2'b00;   // Register file value
  localparam logic [1:0] FwdWriteback = 2'b01;   // Result from Writeback
  localparam logic [1:0] FwdMemory    = 2'b10;   // ALU result in Memory

  localparam logic [3:0] CondAlways   = 4'b1110;

endpackage

/* source/condUnit.sv */
module condUnit (
  input  logic [3:0] cond,
  input  logic [3:0] flags,
  input  logic [3:0] aluFlags,
  input  logic [1:0] flagWrite,
  output logic       condEx,
  output logic [3:0] flagsNext
);
  import ctrlPkg::*;

  logic neg;                                     // Stored N
  logic zero;                                    // Stored Z
  logic carry;                                   // Stored C
  logic overflow;                                // Stored V
  logic ge;                                      // Signed greater or equal

  assign neg      = flags[FlagN];
  assign zero     = flags[FlagZ];
  assign carry    = flags[FlagC];
  assign overflow = flags[FlagV];
  assign ge       = (neg == overflow);

  always_comb begin
    case (cond)
      4'b0000:    condEx = zero;                 // EQ
      4'b0001:    condEx = ~zero;                // NE
      4'b0010:    condEx = carry;                // CS
      4'b0011:    condEx = ~carry;               // CC
      4'b0100:    condEx = neg;                  // MI
      4'b0101:    condEx = ~neg;                 // PL
      4'b0110:    condEx = overflow;             // VS
      4'b0111:    condEx = ~overflow;            // VC
      4'b1000:    condEx = carry & ~zero;        // HI
      4'b1001:    condEx = ~carry | zero;        // LS
      4'b1010:    condEx = ge;                   // GE
      4'b1011:    condEx = ~ge;                  // LT
      4'b1100:    condEx = ~zero & ge;           // GT
      4'b1101:    condEx = zero | ~ge;           // LE
      CondAlways: condEx = 1'b1;                 // AL
      default:    condEx = 1'b0;                 // Unconditional space, not supported
    endcase
  end

  // N and Z follow S, C and V only for add and subtract
  assign flagsNext[FlagN] = (flagWrite[1] & condEx) ? aluFlags[FlagN] : neg;
  assign flagsNext[FlagZ] = (flagWrite[1] & condEx) ? aluFlags[FlagZ] : zero;
  assign flagsNext[FlagC] = (flagWrite[0] & condEx) ? aluFlags[FlagC] : carry;
  assign flagsNext[FlagV] = (flagWrite[0] & condEx) ? aluFlags[FlagV] : overflow;

  // A flag-setting instruction must never reach Execute with cond 1111
  always_comb begin
    assert final (!(cond === 4'b1111 && flagWrite != 2'b00))
      else $error("condUnit: flag write with cond 1111");
  end

endmodule

/* source/controller.sv */
module controller (
  input  logic                clk,
  input  logic                rstN,
  input  ctrlPkg::instrFieldsU instrD,
  input  logic [3:0]          aluFlagsE,
  input  logic                flushE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic                swapAluD,
  output logic                aluSrcE,
  output logic [3:0]          aluControlE,
  output logic                branchTakenE,
  output logic                carryInE,
  output logic                memWriteM,
  output logic                memToRegE,
  output logic                regWriteM,
  output logic                memToRegW,
  output logic                pcSrcW,
  output logic                regWriteW,
  output logic                pcWrPendingF
);
  import ctrlPkg::*;

  logic [9:0] controlsD;                         // Main decoder word
  logic       aluSrcD, memToRegD, regWriteD, memWriteD, branchD, aluOpD;
  logic [3:0] aluControlD;
  logic [1:0] flagWriteD;
  logic       cmpD;                              // Compare family, flags only
  logic       regWriteDecD;                      // Register write after compare check
  logic       pcSrcD;
  logic [1:0] flagWriteE;
  logic       branchE, memWriteE, regWriteE, pcSrcE;
  logic [3:0] condE;
  logic [3:0] flagsE, flagsNextE;
  logic       condExE;
  logic       regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic       memToRegM, pcSrcM;

  // Main decoder
  always_comb begin
    case (instrD.dp.op)
      OpDataProc: controlsD = instrD.dp.immFlag ? 10'b00_00_1_0_1_0_0_1   // DP immediate
                                                : 10'b00_00_0_0_1_0_0_1;  // DP register
      OpMemory:   controlsD = instrD.mem.load   ? 10'b00_01_1_1_1_0_0_0   // LDR
                                                : 10'b10_01_1_0_0_1_0_0;  // STR
      OpBranch:   controlsD = 10'b01_10_1_0_0_0_1_0;                      // B
      default:    controlsD = 10'b0;                                      // Undefined
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memToRegD,
          regWriteD, memWriteD, branchD, aluOpD} = controlsD;

  // ALU decoder
  always_comb begin
    if (aluOpD) begin
      aluControlD   = instrD.dp.cmd;             // cmd goes straight through
      flagWriteD[1] = instrD.dp.sBit;            // N, Z
      flagWriteD[0] = instrD.dp.sBit &
                      (instrD.dp.cmd == CmdAdd || instrD.dp.cmd == CmdSub); // C, V
    end else begin
      aluControlD   = CmdAdd;                    // Address or target add
      flagWriteD    = 2'b00;
    end
  end

  assign cmpD         = aluOpD & (instrD.dp.cmd[3:2] == CmdCmpGroup);
  assign regWriteDecD = regWriteD & ~cmpD;
  assign swapAluD     = aluOpD & (instrD.dp.cmd == CmdRsb || instrD.dp.cmd == CmdRsc);
  assign pcSrcD       = ((instrD.dp.rd == 4'b1111) & regWriteDecD) | branchD; // Write to r15

  // Execute registers cleared to a bubble on flushE
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      flagWriteE <= 2'b00;
      branchE    <= 1'b0;
      memWriteE  <= 1'b0;
      regWriteE  <= 1'b0;
      pcSrcE     <= 1'b0;
      memToRegE  <= 1'b0;
    end else begin
      flagWriteE <= flagWriteD;
      branchE    <= branchD;
      memWriteE  <= memWriteD;
      regWriteE  <= regWriteDecD;
      pcSrcE     <= pcSrcD;
      memToRegE  <= memToRegD;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluSrcE     <= 1'b0;
      aluControlE <= 4'b0;
      condE       <= 4'b0;
      flagsE      <= 4'b0;
    end else begin
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      condE       <= instrD.dp.cond;
      flagsE      <= flagsNextE;                 // Flags update at end of Execute
    end
  end

  condUnit u_condUnit (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  assign branchTakenE   = branchE & condExE;
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;
  assign carryInE       = flagsE[FlagC];         // For ADC, SBC, RSC

  // Memory and Writeback registers
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
      memToRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else begin
      memWriteM <= memWriteGatedE;
      memToRegM <= memToRegE;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
      memToRegW <= memToRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM; // PC write somewhere ahead of W

  aDecodeKnown: assert property (@(posedge clk) disable iff (!rstN)
    (instrD.dp.op != 2'b11) |-> !$isunknown(controlsD));

  // A store in Memory must not come out of Writeback as a load
  aStoreNotLoad: assert property (@(posedge clk) disable iff (!rstN)
    memWriteM |=> !memToRegW);

endmodule

/* source/hazardUnit.sv */
module hazardUnit (
  input  logic       clk,
  input  logic       rstN,
  input  logic       match1EM,                   // Operand 1 of E equals dest in M
  input  logic       match1EW,                   // Operand 1 of E equals dest in W
  input  logic       match2EM,
  input  logic       match2EW,
  input  logic       match12DE,                  // D source equals E dest
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       memToRegE,
  input  logic       pcWrPendingF,
  input  logic       pcSrcW,
  input  logic       branchTakenE,
  output logic [1:0] forwardAE,
  output logic [1:0] forwardBE,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);
  import ctrlPkg::*;

  logic ldStallD;                                // Load-use hazard

  // Memory result is younger, so it wins over Writeback
  function automatic logic [1:0] fwdSel(
    input logic matchM,
    input logic matchW,
    input logic wrM,
    input logic wrW
  );
    logic [1:0] sel;
    if (matchM && wrM) begin
      sel = FwdMemory;
    end else if (matchW && wrW) begin
      sel = FwdWriteback;
    end else begin
      sel = FwdNone;
    end
    return sel;
  endfunction

  assign forwardAE = fwdSel(match1EM, match1EW, regWriteM, regWriteW);
  assign forwardBE = fwdSel(match2EM, match2EW, regWriteM, regWriteW);

  assign ldStallD = match12DE & memToRegE;       // Load data not ready until W

  assign stallF = ldStallD | pcWrPendingF;       // Hold fetch while PC write pending
  assign stallD = ldStallD;
  assign flushD = pcWrPendingF | pcSrcW | branchTakenE;
  assign flushE = ldStallD | branchTakenE;       // Bubble behind stalled instruction

  aStallOrder: assert property (@(posedge clk) disable iff (!rstN)
    stallD |-> stallF);

  aFlushStall: assert property (@(posedge clk) disable iff (!rstN)
    (flushE && stallD) |-> ldStallD);

endmodule

/* source/ctrlTop.sv */
module ctrlTop (
  input  logic         clk,
  input  logic         rstN,
  input  logic [31:12] instrD,
  input  logic [3:0]   aluFlagsE,
  input  logic         match1EM,
  input  logic         match1EW,
  input  logic         match2EM,
  input  logic         match2EW,
  input  logic         match12DE,
  output logic [1:0]   regSrcD,
  output logic [1:0]   immSrcD,
  output logic         swapAluD,
  output logic         aluSrcE,
  output logic [3:0]   aluControlE,
  output logic         branchTakenE,
  output logic         carryInE,
  output logic         memWriteM,
  output logic         memToRegW,
  output logic         pcSrcW,
  output logic         regWriteW,
  output logic [1:0]   forwardAE,
  output logic [1:0]   forwardBE,
  output logic         stallF,
  output logic         stallD,
  output logic         flushD
);

  logic regWriteM;                               // Controller to hazard unit
  logic memToRegE;
  logic pcWrPendingF;
  logic flushE;                                  // Hazard unit back to controller

  controller u_controller (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .flushE       (flushE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .swapAluD     (swapAluD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .carryInE     (carryInE),
    .memWriteM    (memWriteM),
    .memToRegE    (memToRegE),
    .regWriteM    (regWriteM),
    .memToRegW    (memToRegW),
    .pcSrcW       (pcSrcW),
    .regWriteW    (regWriteW),
    .pcWrPendingF (pcWrPendingF)
  );

  hazardUnit u_hazardUnit (
    .clk          (clk),
    .rstN         (rstN),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match12DE    (match12DE),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memToRegE    (memToRegE),
    .pcWrPendingF (pcWrPendingF),
    .pcSrcW       (pcSrcW),
    .branchTakenE (branchTakenE),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE)
  );

endmodule

/* verif/tbClock.sv */
module tbClock (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod = 4;                 // 8 ns period

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Sync reset, low over three rising edges
  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clk);
    #1;                                          // Same drive offset as stimulus
    rstN = 1'b1;
  end

endmodule

/* verif/ctrlTb.sv */
module ctrlTb;
  timeunit 1ns;
  timeprecision 100ps;
  import ctrlPkg::*;

  localparam int StageTimeout = 10;              // Cycles before a wait gives up
  localparam int SelMemWrite  = 0;               // Probe selects
  localparam int SelMemToReg  = 1;
  localparam int SelRegWrite  = 2;
  localparam int SelPcSrc     = 3;

  logic        clk, rstN;
  instrFieldsU instrD;
  logic [3:0]  aluFlagsE;                        // ALU flags from the modelled datapath
  logic        match1EM, match1EW, match2EM, match2EW, match12DE;
  logic [1:0]  regSrcD, immSrcD, forwardAE, forwardBE;
  logic [3:0]  aluControlE;
  logic        swapAluD, aluSrcE, branchTakenE, carryInE, memWriteM;
  logic        memToRegW, pcSrcW, regWriteW, stallF, stallD, flushD;
  int          seed;

  tbClock u_clock (.clk(clk), .rstN(rstN));

  ctrlTop u_dut (
    .clk(clk), .rstN(rstN), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM),
    .match2EW(match2EW), .match12DE(match12DE),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .swapAluD(swapAluD), .aluSrcE(aluSrcE),
    .aluControlE(aluControlE), .branchTakenE(branchTakenE), .carryInE(carryInE),
    .memWriteM(memWriteM), .memToRegW(memToRegW), .pcSrcW(pcSrcW),
    .regWriteW(regWriteW), .forwardAE(forwardAE), .forwardBE(forwardBE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD)
  );

  function automatic instrFieldsU dpInstr(input logic [3:0] cond, input logic imm,
                                          input logic [3:0] cmd, input logic s,
                                          input logic [3:0] rd);
    return {cond, OpDataProc, imm, cmd, s, 4'd1, rd};  // rn fixed at r1
  endfunction

  function automatic instrFieldsU memInstr(input logic load, input logic [3:0] rd);
    instrFieldsU w;
    w = '0;
    w.mem.cond     = CondAlways;
    w.mem.op       = OpMemory;
    w.mem.preIndex = 1'b1;                       // Plain offset addressing
    w.mem.up       = 1'b1;
    w.mem.load     = load;
    w.mem.rn       = 4'd2;
    w.mem.rd       = rd;
    return w;
  endfunction

  function automatic instrFieldsU brInstr(input logic [3:0] cond);
    return {cond, OpBranch, 14'd0};
  endfunction

  // TST without S touches no register, flag or memory
  function automatic instrFieldsU nopInstr();
    return dpInstr(CondAlways, 1'b0, 4'b1000, 1'b0, 4'd0);
  endfunction

  // Reference condition table on N Z C V
  function automatic logic condModel(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    n = f[3];
    z = f[2];
    c = f[1];
    v = f[0];
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'ha: return n == v;
      4'hb: return n != v;
      4'hc: return !z && (n == v);
      4'hd: return z || (n != v);
      default: return 1'b1;                      // AL
    endcase
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SelMemWrite: return memWriteM;
      SelMemToReg: return memToRegW;
      SelRegWrite: return regWriteW;
      default:     return pcSrcW;
    endcase
  endfunction

  task automatic stopRun();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkVal(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;                                          // Drive point after the edge
  endtask

  // Register read and immediate selects follow the operand format of the class
  task automatic decodeSelects(input instrFieldsU instr, input logic [1:0] regSrc,
                               input logic [1:0] immSrc);
    instrD = instr;
    #1;
    checkVal("regSrcD", regSrcD, regSrc);
    checkVal("immSrcD", immSrcD, immSrc);
  endtask

  // One clock in Decode followed by a bubble
  task automatic issue(input instrFieldsU instr);
    instrD = instr;
    nextCycle();
    instrD = nopInstr();
  endtask

  task automatic drain();
    instrD = nopInstr();
    repeat (4) nextCycle();                      // Empties E, M and W
  endtask

  task automatic setMatch(input logic m1M, input logic m1W, input logic m2M,
                          input logic m2W);
    match1EM = m1M;
    match1EW = m1W;
    match2EM = m2M;
    match2EW = m2W;
    #1;
  endtask

  // Latency counted from Decode since issue already took one edge
  task automatic waitRise(input int sel, input string name, input int lat);
    int cnt;
    cnt = 1;
    while (!probe(sel) && cnt < StageTimeout) begin
      nextCycle();
      cnt++;
    end
    assert (probe(sel)) else begin
      $display("timeout: %s never went high", name);
      stopRun();
    end
    checkVal({name, " latency"}, cnt, lat);
  endtask

  task automatic waitReset();
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (!rstN && cnt < StageTimeout) begin
      @(posedge clk);                            // rstN stable at the edge
      cnt++;
    end
    assert (rstN) else begin
      $display("timeout: reset was never released");
      stopRun();
    end
    #1;
  endtask

  task automatic resetOutputs();
    checkVal("memWriteM", memWriteM, 0);
    checkVal("regWriteW", regWriteW, 0);
    checkVal("pcSrcW", pcSrcW, 0);
    checkVal("memToRegW", memToRegW, 0);
    checkVal("branchTakenE", branchTakenE, 0);
    checkVal("stallF", stallF, 0);
    checkVal("stallD", stallD, 0);
    checkVal("flushD", flushD, 0);
  endtask

  task automatic dataProcessing();
    instrFieldsU instr;
    for (int i = 0; i < 16; i++) begin
      instr = dpInstr(CondAlways, i[0] ^ i[2], i[3:0], 1'b0, 4'd5);
      drain();
      decodeSelects(instr, 2'b00, 2'b00);        // Rn and Rm, 8-bit immediate
      checkVal("swapAluD", swapAluD, (instr.dp.cmd == CmdRsb) || (instr.dp.cmd == CmdRsc));
      issue(instr);
      checkVal("aluControlE", aluControlE, instr.dp.cmd);
      checkVal("aluSrcE", aluSrcE, instr.dp.immFlag);
      if (instr.dp.cmd[3:2] == 2'b10) begin      // Compare family sets flags only
        repeat (3) begin
          checkVal("regWriteW", regWriteW, 0);
          nextCycle();
        end
      end else begin
        waitRise(SelRegWrite, "regWriteW", 3);
      end
    end
  endtask

  task automatic conditionCodes();
    logic [3:0] flagsRnd, cond;
    for (int i = 0; i < 20; i++) begin
      flagsRnd = $random(seed);
      cond     = $unsigned($random(seed)) % 15;  // 1111 left out
      drain();
      issue(dpInstr(CondAlways, 1'b1, CmdAdd, 1'b1, 4'd1));  // ADDS now in E
      aluFlagsE = flagsRnd;
      issue(brInstr(cond));                      // B in E with flags loaded
      aluFlagsE = ~flagsRnd;                     // B writes no flags
      #1;
      checkVal("branchTakenE", branchTakenE, condModel(cond, flagsRnd));
      checkVal("carryInE", carryInE, flagsRnd[FlagC]);
    end
  endtask

  task automatic loadStore();
    instrFieldsU ldr;
    ldr = memInstr(1'b1, 4'd3);
    drain();
    decodeSelects(memInstr(1'b0, 4'd3), 2'b10, 2'b01);  // Rd read as data, 12-bit offset
    issue(memInstr(1'b0, 4'd3));                 // STR
    waitRise(SelMemWrite, "memWriteM", 2);
    drain();
    decodeSelects(ldr, 2'b00, 2'b01);
    issue(ldr);
    waitRise(SelMemToReg, "memToRegW", 3);
    checkVal("regWriteW", regWriteW, 1);
    drain();
    issue(ldr);                                  // LDR in E
    instrD    = dpInstr(CondAlways, 1'b0, CmdAdd, 1'b0, 4'd4);
    match12DE = 1'b1;                            // ADD reads r3
    #1;
    checkVal("stallF", stallF, 1);
    checkVal("stallD", stallD, 1);
    nextCycle();                                 // ADD held in D with a bubble in E
    match12DE = 1'b0;
    nextCycle();                                 // ADD in E and LDR in W
    instrD = nopInstr();
    checkVal("memToRegW", memToRegW, 1);
    checkVal("regWriteW", regWriteW, 1);
    nextCycle();                                 // Bubble reaches W
    checkVal("regWriteW", regWriteW, 0);
    nextCycle();
    checkVal("regWriteW", regWriteW, 1);         // Replayed ADD
  endtask

  task automatic forwardPriority();
    drain();
    issue(dpInstr(CondAlways, 1'b1, CmdAdd, 1'b0, 4'd6));
    issue(dpInstr(CondAlways, 1'b1, CmdSub, 1'b0, 4'd7));
    nextCycle();                                 // ADD in W and SUB in M
    checkVal("regWriteW", regWriteW, 1);
    setMatch(1, 1, 1, 1);
    checkVal("forwardAE", forwardAE, FwdMemory);
    checkVal("forwardBE", forwardBE, FwdMemory);
    setMatch(0, 1, 0, 1);
    checkVal("forwardAE", forwardAE, FwdWriteback);
    checkVal("forwardBE", forwardBE, FwdWriteback);
    setMatch(1, 0, 0, 1);                        // Operands pick independently
    checkVal("forwardAE", forwardAE, FwdMemory);
    checkVal("forwardBE", forwardBE, FwdWriteback);
    setMatch(0, 0, 0, 0);
    checkVal("forwardAE", forwardAE, FwdNone);
    checkVal("forwardBE", forwardBE, FwdNone);
  endtask

  task automatic pcWrite();
    int cnt;
    drain();
    instrD = dpInstr(CondAlways, 1'b1, CmdAdd, 1'b0, 4'd15);  // ADD into r15
    #1;
    cnt = 0;
    while (!pcSrcW && cnt < StageTimeout) begin
      checkVal("stallF", stallF, 1);             // PC write still pending
      checkVal("flushD", flushD, 1);
      nextCycle();
      instrD = nopInstr();
      #1;
      cnt++;
    end
    assert (pcSrcW) else begin
      $display("timeout: pcSrcW never went high");
      stopRun();
    end
    checkVal("pcSrcW latency", cnt, 3);
    drain();
    decodeSelects(brInstr(CondAlways), 2'b01, 2'b10);  // PC as Rn, 24-bit offset
    issue(brInstr(CondAlways));
    #1;
    checkVal("branchTakenE", branchTakenE, 1);
    checkVal("flushD", flushD, 1);               // Taken branch kills Decode
  endtask

  initial begin
    seed      = 17;
    instrD    = nopInstr();
    aluFlagsE = 4'b0;
    match1EM  = 1'b0;
    match1EW  = 1'b0;
    match2EM  = 1'b0;
    match2EW  = 1'b0;
    match12DE = 1'b0;
    waitReset();
    resetOutputs();
    dataProcessing();
    conditionCodes();
    loadStore();
    forwardPriority();
    pcWrite();
    drain();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* src.f */
source/ctrlPkg.sv
source/condUnit.sv
source/controller.sv
source/hazardUnit.sv
source/ctrlTop.sv
verif/tbClock.sv
verif/ctrlTb.sv

/* Bender.yml */
package:
  name: ctrl_pipeline

sources:
  - files:
      - source/ctrlPkg.sv
      - source/condUnit.sv
      - source/controller.sv
      - source/hazardUnit.sv
      - source/ctrlTop.sv
  - target: test
    files:
      - verif/tbClock.sv
      - verif/ctrlTb.sv
